// File: source/udp_echo_pkg.sv
package udp_echo_pkg;

    // Field types shared by all three stages
    typedef logic [7:0] byte_t;

    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    typedef logic [15:0] udp_len_t;

    typedef logic [7:0] ttl_t;

    // Every reply leaves with this TTL
    localparam ttl_t REPLY_TTL = 8'd64;

    // Reply builder states
    // IDLE  no header held
    // HDR   reply header offered on tx
    // BODY  payload of the current reply forwarded from the FIFO
    typedef enum logic [1:0] {
        IDLE,
        HDR,
        BODY
    } builder_state_t;

endpackage

// File: source/udp_port_filter.sv
module udp_port_filter #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT = 16'd1234
) (
    input  logic                    clk,
    input  logic                    rst,
    // Header from the UDP stack
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_src_ip,
    input  udp_echo_pkg::udp_port_t rx_src_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,
    // Payload from the UDP stack
    input  udp_echo_pkg::byte_t     rx_payload_data,
    input  logic                    rx_payload_valid,
    output logic                    rx_payload_ready,
    input  logic                    rx_payload_last,
    input  logic                    rx_payload_user,
    // Request to the reply builder
    output logic                    req_valid,
    input  logic                    req_ready,
    output udp_echo_pkg::ip_addr_t  req_ip,
    output udp_echo_pkg::udp_port_t req_src_port,
    output udp_echo_pkg::udp_port_t req_dest_port,
    output udp_echo_pkg::udp_len_t  req_length,
    // Payload into the FIFO
    output logic                    wr_valid,
    input  logic                    wr_ready,
    output udp_echo_pkg::byte_t     wr_data,
    output logic                    wr_last,
    output logic                    wr_user
);

    logic match;
    logic pass_mode;
    logic drop_mode;
    logic idle;
    logic hdr_fire;
    logic last_fire;

    assign match = (rx_dest_port == ECHO_PORT);
    assign idle  = !pass_mode && !drop_mode;

    // Matching headers leave only together with a request
    assign req_valid     = rx_hdr_valid && idle && match;
    assign req_ip        = rx_src_ip;
    assign req_src_port  = rx_src_port;
    assign req_dest_port = rx_dest_port;
    assign req_length    = rx_length;

    // Other ports are swallowed without waiting on the builder
    assign rx_hdr_ready = rx_hdr_valid && idle && (match ? req_ready : 1'b1);

    assign hdr_fire = rx_hdr_valid && rx_hdr_ready;

    // Payload steering
    assign wr_valid = rx_payload_valid && pass_mode;
    assign wr_data  = rx_payload_data;
    assign wr_last  = rx_payload_last;
    assign wr_user  = rx_payload_user;

    assign rx_payload_ready = pass_mode ? wr_ready : drop_mode;

    assign last_fire = rx_payload_valid && rx_payload_ready && rx_payload_last;

    // Mode holds from header acceptance until the last payload beat
    always_ff @(posedge clk) begin
        if (rst) begin
            pass_mode <= 1'b0;
            drop_mode <= 1'b0;
        end else if (hdr_fire) begin
            pass_mode <= match;
            drop_mode <= !match;
        end else if (last_fire) begin
            pass_mode <= 1'b0;
            drop_mode <= 1'b0;
        end
    end

    // A discarded datagram must not leak its first byte into the FIFO
    assert property (@(posedge clk) disable iff (rst)
        (hdr_fire && !match) |=> !wr_valid && drop_mode)
        else $error("payload of a dropped datagram reached the FIFO");

endmodule

// File: source/payload_fifo.sv
module payload_fifo #(
    parameter int FIFO_ADDR_WIDTH = 6
) (
    input  logic                clk,
    input  logic                rst,
    // Write side
    input  logic                wr_valid,
    output logic                wr_ready,
    input  udp_echo_pkg::byte_t wr_data,
    input  logic                wr_last,
    input  logic                wr_user,
    // Read side
    output logic                rd_valid,
    input  logic                rd_ready,
    output udp_echo_pkg::byte_t rd_data,
    output logic                rd_last,
    output logic                rd_user
);

    localparam logic [FIFO_ADDR_WIDTH:0] DEPTH = {1'b1, {FIFO_ADDR_WIDTH{1'b0}}};

    // Entry layout is {user, last, data}
    logic [9:0] mem [DEPTH];

    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr;
    logic [FIFO_ADDR_WIDTH:0]   count;
    logic                       wr_fire;
    logic                       rd_fire;
    logic [9:0]                 rd_entry;

    assign wr_ready = (count != DEPTH);
    assign rd_valid = (count != '0);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // Storage
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= {wr_user, wr_last, wr_data};
        end
    end

    assign rd_entry = mem[rd_ptr];
    assign rd_data  = rd_entry[7:0];
    assign rd_last  = rd_entry[8];
    assign rd_user  = rd_entry[9];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy stays within 0..DEPTH across every update
    assert property (@(posedge clk) disable iff (rst)
        (count == '0) |=> (count <= 1))
        else $error("FIFO occupancy wrapped below zero");

    assert property (@(posedge clk) disable iff (rst)
        (count == DEPTH) |=> (count == DEPTH || count == DEPTH - 1'b1))
        else $error("FIFO occupancy exceeded depth");

endmodule

// File: source/reply_builder.sv
module reply_builder #(
    parameter udp_echo_pkg::ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128}
) (
    input  logic                    clk,
    input  logic                    rst,
    // Request from the filter
    input  logic                    req_valid,
    output logic                    req_ready,
    input  udp_echo_pkg::ip_addr_t  req_ip,
    input  udp_echo_pkg::udp_port_t req_src_port,
    input  udp_echo_pkg::udp_port_t req_dest_port,
    input  udp_echo_pkg::udp_len_t  req_length,
    // Payload from the FIFO
    input  logic                    rd_valid,
    output logic                    rd_ready,
    input  udp_echo_pkg::byte_t     rd_data,
    input  logic                    rd_last,
    input  logic                    rd_user,
    // Reply header
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dest_ip,
    output udp_echo_pkg::ttl_t      tx_ttl,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    // Reply payload
    output udp_echo_pkg::byte_t     tx_payload_data,
    output logic                    tx_payload_valid,
    input  logic                    tx_payload_ready,
    output logic                    tx_payload_last,
    output logic                    tx_payload_user,
    output udp_echo_pkg::byte_t     led
);

    udp_echo_pkg::builder_state_t state;

    logic                    pend_valid;
    udp_echo_pkg::ip_addr_t  pend_ip;
    udp_echo_pkg::udp_port_t pend_src_port;
    udp_echo_pkg::udp_port_t pend_dest_port;
    udp_echo_pkg::udp_len_t  pend_length;

    udp_echo_pkg::ip_addr_t  act_ip;
    udp_echo_pkg::udp_port_t act_src_port;
    udp_echo_pkg::udp_port_t act_dest_port;
    udp_echo_pkg::udp_len_t  act_length;

    logic first_beat;
    logic req_fire;
    logic hdr_fire;
    logic pay_fire;
    logic body_done;
    logic load_req;
    logic load_pend;

    // No new request while a header waits on tx
    assign req_ready = (state != udp_echo_pkg::HDR) && !pend_valid;
    assign req_fire  = req_valid && req_ready;

    assign hdr_fire  = tx_hdr_valid && tx_hdr_ready;
    assign pay_fire  = tx_payload_valid && tx_payload_ready;
    assign body_done = pay_fire && rd_last;

    // Request goes straight to the active register when it is free
    assign load_req  = req_fire && ((state == udp_echo_pkg::IDLE) || (body_done && !pend_valid));
    assign load_pend = body_done && pend_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (req_fire && !load_req) begin
            pend_valid <= 1'b1;
        end else if (load_pend) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire && !load_req) begin
            pend_ip        <= req_ip;
            pend_src_port  <= req_src_port;
            pend_dest_port <= req_dest_port;
            pend_length    <= req_length;
        end
        if (load_req) begin
            act_ip        <= req_ip;
            act_src_port  <= req_src_port;
            act_dest_port <= req_dest_port;
            act_length    <= req_length;
        end else if (load_pend) begin
            act_ip        <= pend_ip;
            act_src_port  <= pend_src_port;
            act_dest_port <= pend_dest_port;
            act_length    <= pend_length;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= udp_echo_pkg::IDLE;
        end else begin
            case (state)
                udp_echo_pkg::IDLE: begin
                    if (req_fire) begin
                        state <= udp_echo_pkg::HDR;
                    end
                end
                udp_echo_pkg::HDR: begin
                    if (tx_hdr_ready) begin
                        state <= udp_echo_pkg::BODY;
                    end
                end
                udp_echo_pkg::BODY: begin
                    if (body_done) begin
                        state <= (pend_valid || req_fire) ? udp_echo_pkg::HDR
                                                          : udp_echo_pkg::IDLE;
                    end
                end
                default: state <= udp_echo_pkg::IDLE;
            endcase
        end
    end

    // Reply header with ports swapped
    assign tx_hdr_valid = (state == udp_echo_pkg::HDR);
    assign tx_src_ip    = LOCAL_IP;
    assign tx_dest_ip   = act_ip;
    assign tx_ttl       = udp_echo_pkg::REPLY_TTL;
    assign tx_src_port  = act_dest_port;
    assign tx_dest_port = act_src_port;
    assign tx_length    = act_length;

    assign tx_payload_valid = (state == udp_echo_pkg::BODY) && rd_valid;
    assign rd_ready         = (state == udp_echo_pkg::BODY) && tx_payload_ready;
    assign tx_payload_data  = rd_data;
    assign tx_payload_last  = rd_last;
    assign tx_payload_user  = rd_user;

    // First byte of each reply goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat <= 1'b0;
            led        <= '0;
        end else begin
            if (hdr_fire) begin
                first_beat <= 1'b1;
            end else if (pay_fire) begin
                first_beat <= 1'b0;
            end
            if (pay_fire && first_beat) begin
                led <= tx_payload_data;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (tx_hdr_valid && !tx_hdr_ready) |=> tx_hdr_valid && $stable(tx_dest_ip)
            && $stable(tx_src_port) && $stable(tx_dest_port) && $stable(tx_length))
        else $error("reply header changed while stalled");

endmodule

// File: source/udp_echo_top.sv
module udp_echo_top #(
    parameter udp_echo_pkg::udp_port_t ECHO_PORT       = 16'd1234,
    parameter udp_echo_pkg::ip_addr_t  LOCAL_IP        = {8'd192, 8'd168, 8'd1, 8'd128},
    parameter int                      FIFO_ADDR_WIDTH = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rx_hdr_valid,
    output logic                    rx_hdr_ready,
    input  udp_echo_pkg::ip_addr_t  rx_src_ip,
    input  udp_echo_pkg::udp_port_t rx_src_port,
    input  udp_echo_pkg::udp_port_t rx_dest_port,
    input  udp_echo_pkg::udp_len_t  rx_length,
    input  udp_echo_pkg::byte_t     rx_payload_data,
    input  logic                    rx_payload_valid,
    output logic                    rx_payload_ready,
    input  logic                    rx_payload_last,
    input  logic                    rx_payload_user,
    output logic                    tx_hdr_valid,
    input  logic                    tx_hdr_ready,
    output udp_echo_pkg::ip_addr_t  tx_src_ip,
    output udp_echo_pkg::ip_addr_t  tx_dest_ip,
    output udp_echo_pkg::ttl_t      tx_ttl,
    output udp_echo_pkg::udp_port_t tx_src_port,
    output udp_echo_pkg::udp_port_t tx_dest_port,
    output udp_echo_pkg::udp_len_t  tx_length,
    output udp_echo_pkg::byte_t     tx_payload_data,
    output logic                    tx_payload_valid,
    input  logic                    tx_payload_ready,
    output logic                    tx_payload_last,
    output logic                    tx_payload_user,
    output udp_echo_pkg::byte_t     led
);

    // Filter to builder
    logic                    req_valid;
    logic                    req_ready;
    udp_echo_pkg::ip_addr_t  req_ip;
    udp_echo_pkg::udp_port_t req_src_port;
    udp_echo_pkg::udp_port_t req_dest_port;
    udp_echo_pkg::udp_len_t  req_length;

    // Filter to FIFO
    logic                wr_valid;
    logic                wr_ready;
    udp_echo_pkg::byte_t wr_data;
    logic                wr_last;
    logic                wr_user;

    // FIFO to builder
    logic                rd_valid;
    logic                rd_ready;
    udp_echo_pkg::byte_t rd_data;
    logic                rd_last;
    logic                rd_user;

    udp_port_filter #(
        .ECHO_PORT(ECHO_PORT)
    ) filter_inst (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_src_ip       (rx_src_ip),
        .rx_src_port     (rx_src_port),
        .rx_dest_port    (rx_dest_port),
        .rx_length       (rx_length),
        .rx_payload_data (rx_payload_data),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .rx_payload_last (rx_payload_last),
        .rx_payload_user (rx_payload_user),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_ip          (req_ip),
        .req_src_port    (req_src_port),
        .req_dest_port   (req_dest_port),
        .req_length      (req_length),
        .wr_valid        (wr_valid),
        .wr_ready        (wr_ready),
        .wr_data         (wr_data),
        .wr_last         (wr_last),
        .wr_user         (wr_user)
    );

    payload_fifo #(
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) fifo_inst (
        .clk     (clk),
        .rst     (rst),
        .wr_valid(wr_valid),
        .wr_ready(wr_ready),
        .wr_data (wr_data),
        .wr_last (wr_last),
        .wr_user (wr_user),
        .rd_valid(rd_valid),
        .rd_ready(rd_ready),
        .rd_data (rd_data),
        .rd_last (rd_last),
        .rd_user (rd_user)
    );

    reply_builder #(
        .LOCAL_IP(LOCAL_IP)
    ) builder_inst (
        .clk             (clk),
        .rst             (rst),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .req_ip          (req_ip),
        .req_src_port    (req_src_port),
        .req_dest_port   (req_dest_port),
        .req_length      (req_length),
        .rd_valid        (rd_valid),
        .rd_ready        (rd_ready),
        .rd_data         (rd_data),
        .rd_last         (rd_last),
        .rd_user         (rd_user),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_src_ip       (tx_src_ip),
        .tx_dest_ip      (tx_dest_ip),
        .tx_ttl          (tx_ttl),
        .tx_src_port     (tx_src_port),
        .tx_dest_port    (tx_dest_port),
        .tx_length       (tx_length),
        .tx_payload_data (tx_payload_data),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_last (tx_payload_last),
        .tx_payload_user (tx_payload_user),
        .led             (led)
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int HALF_PERIOD = 20,
    parameter int RST_CYCLES  = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verif/tb_udp_echo.sv
module tb_udp_echo;
    timeunit 1ns;
    timeprecision 100ps;

    localparam udp_echo_pkg::udp_port_t ECHO_PORT       = 16'd1234;
    localparam udp_echo_pkg::ip_addr_t  LOCAL_IP        = 32'hc0a8_0180;
    localparam int                      FIFO_ADDR_WIDTH = 6;
    localparam int                      RST_CYCLES      = 8;
    localparam int                      NUM             = 8;

    // One request: sender, ports, payload bytes, first byte, error flag
    typedef struct packed {
        udp_echo_pkg::ip_addr_t  ip;
        udp_echo_pkg::udp_port_t sport;
        udp_echo_pkg::udp_port_t dport;
        logic [15:0]             len;
        udp_echo_pkg::byte_t     first;
        logic                    err;
    } entry_t;

    logic clk;
    logic rst;

    logic                    rx_hdr_valid;
    logic                    rx_hdr_ready;
    udp_echo_pkg::ip_addr_t  rx_src_ip;
    udp_echo_pkg::udp_port_t rx_src_port;
    udp_echo_pkg::udp_port_t rx_dest_port;
    udp_echo_pkg::udp_len_t  rx_length;
    udp_echo_pkg::byte_t     rx_payload_data;
    logic                    rx_payload_valid;
    logic                    rx_payload_ready;
    logic                    rx_payload_last;
    logic                    rx_payload_user;
    logic                    tx_hdr_valid;
    logic                    tx_hdr_ready;
    udp_echo_pkg::ip_addr_t  tx_src_ip;
    udp_echo_pkg::ip_addr_t  tx_dest_ip;
    udp_echo_pkg::ttl_t      tx_ttl;
    udp_echo_pkg::udp_port_t tx_src_port;
    udp_echo_pkg::udp_port_t tx_dest_port;
    udp_echo_pkg::udp_len_t  tx_length;
    udp_echo_pkg::byte_t     tx_payload_data;
    logic                    tx_payload_valid;
    logic                    tx_payload_ready;
    logic                    tx_payload_last;
    logic                    tx_payload_user;
    udp_echo_pkg::byte_t     led;

    entry_t stim [NUM];

    // Expected replies in request order
    logic [31:0] exp_dest_ip [$];
    logic [15:0] exp_src_port [$];
    logic [15:0] exp_dest_port [$];
    logic [15:0] exp_length [$];
    logic [7:0]  exp_byte [$];
    logic        exp_last [$];
    logic        exp_user [$];

    integer              seed        = 32'hf95febdf;
    int                  cycle_count = 0;
    int                  cycle_limit = 0;
    logic                first_due   = 1'b0;
    logic                led_due     = 1'b0;
    udp_echo_pkg::byte_t led_expect  = '0;

    tb_clk_gen #(
        .HALF_PERIOD(20),
        .RST_CYCLES (RST_CYCLES)
    ) clk_gen_inst (
        .clk(clk),
        .rst(rst)
    );

    udp_echo_top #(
        .ECHO_PORT      (ECHO_PORT),
        .LOCAL_IP       (LOCAL_IP),
        .FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)
    ) uut (
        .clk             (clk),
        .rst             (rst),
        .rx_hdr_valid    (rx_hdr_valid),
        .rx_hdr_ready    (rx_hdr_ready),
        .rx_src_ip       (rx_src_ip),
        .rx_src_port     (rx_src_port),
        .rx_dest_port    (rx_dest_port),
        .rx_length       (rx_length),
        .rx_payload_data (rx_payload_data),
        .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .rx_payload_last (rx_payload_last),
        .rx_payload_user (rx_payload_user),
        .tx_hdr_valid    (tx_hdr_valid),
        .tx_hdr_ready    (tx_hdr_ready),
        .tx_src_ip       (tx_src_ip),
        .tx_dest_ip      (tx_dest_ip),
        .tx_ttl          (tx_ttl),
        .tx_src_port     (tx_src_port),
        .tx_dest_port    (tx_dest_port),
        .tx_length       (tx_length),
        .tx_payload_data (tx_payload_data),
        .tx_payload_valid(tx_payload_valid),
        .tx_payload_ready(tx_payload_ready),
        .tx_payload_last (tx_payload_last),
        .tx_payload_user (tx_payload_user),
        .led             (led)
    );

    task automatic report_failure();
        $display("sim failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            report_failure();
        end
    endtask

    // Header then payload; bytes count up from the first byte
    task automatic apply_entry(input int i);
        udp_echo_pkg::byte_t b;
        logic                last;
        if (stim[i].dport == ECHO_PORT) begin
            exp_dest_ip.push_back(stim[i].ip);
            exp_src_port.push_back(stim[i].dport);
            exp_dest_port.push_back(stim[i].sport);
            exp_length.push_back(stim[i].len + 16'd8);
            for (int n = 0; n < int'(stim[i].len); n++) begin
                exp_byte.push_back(stim[i].first + 8'(n));
                exp_last.push_back(n == int'(stim[i].len) - 1);
                exp_user.push_back(stim[i].err && (n == int'(stim[i].len) - 1));
            end
        end
        @(posedge clk);
        rx_hdr_valid <= 1'b1;
        rx_src_ip    <= stim[i].ip;
        rx_src_port  <= stim[i].sport;
        rx_dest_port <= stim[i].dport;
        rx_length    <= stim[i].len + 16'd8;
        do @(negedge clk); while (!rx_hdr_ready);
        @(posedge clk);
        rx_hdr_valid <= 1'b0;
        for (int n = 0; n < int'(stim[i].len); n++) begin
            b    = stim[i].first + 8'(n);
            last = (n == int'(stim[i].len) - 1);
            rx_payload_valid <= 1'b1;
            rx_payload_data  <= b;
            rx_payload_last  <= last;
            rx_payload_user  <= stim[i].err && last;
            do @(negedge clk); while (!rx_payload_ready);
            @(posedge clk);
        end
        rx_payload_valid <= 1'b0;
        rx_payload_last  <= 1'b0;
        rx_payload_user  <= 1'b0;
    endtask

    // Random back-pressure, ready about one cycle in three
    always @(posedge clk) begin
        tx_hdr_ready     <= ($unsigned($random(seed)) % 3) == 0;
        tx_payload_ready <= ($unsigned($random(seed)) % 3) == 0;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: replies still outstanding after %0d cycles", cycle_limit);
            report_failure();
        end
    end

    // Monitor samples at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!rst) begin
            if (led_due) begin
                check_value("led", 32'(led), 32'(led_expect));
                led_due = 1'b0;
            end
            if (tx_hdr_valid && tx_hdr_ready) begin
                if (exp_dest_ip.size() == 0) begin
                    $display("reply header sent with no matching echo request");
                    report_failure();
                end
                check_value("tx_src_ip", tx_src_ip, LOCAL_IP);
                check_value("tx_dest_ip", tx_dest_ip, exp_dest_ip[0]);
                check_value("tx_ttl", 32'(tx_ttl), 32'd64);
                check_value("tx_src_port", 32'(tx_src_port), 32'(exp_src_port[0]));
                check_value("tx_dest_port", 32'(tx_dest_port), 32'(exp_dest_port[0]));
                check_value("tx_length", 32'(tx_length), 32'(exp_length[0]));
                void'(exp_dest_ip.pop_front());
                void'(exp_src_port.pop_front());
                void'(exp_dest_port.pop_front());
                void'(exp_length.pop_front());
                first_due = 1'b1;
            end
            if (tx_payload_valid && tx_payload_ready) begin
                if (exp_byte.size() == 0) begin
                    $display("reply payload byte sent with none expected");
                    report_failure();
                end
                check_value("tx_payload_data", 32'(tx_payload_data), 32'(exp_byte[0]));
                check_value("tx_payload_last", 32'(tx_payload_last), 32'(exp_last[0]));
                check_value("tx_payload_user", 32'(tx_payload_user), 32'(exp_user[0]));
                if (first_due) begin
                    led_expect = exp_byte[0];
                    led_due    = 1'b1;
                    first_due  = 1'b0;
                end
                void'(exp_byte.pop_front());
                void'(exp_last.pop_front());
                void'(exp_user.pop_front());
            end
        end
    end

    initial begin
        int total;
        rx_hdr_valid     = 1'b0;
        rx_src_ip        = '0;
        rx_src_port      = '0;
        rx_dest_port     = '0;
        rx_length        = '0;
        rx_payload_data  = '0;
        rx_payload_valid = 1'b0;
        rx_payload_last  = 1'b0;
        rx_payload_user  = 1'b0;
        tx_hdr_ready     = 1'b0;
        tx_payload_ready = 1'b0;

        // Long payloads overflow the 64 entry FIFO, dport 80 and 1235 are dropped
        stim[0] = '{32'hc0a8_0105, 16'd5000, 16'd1234, 16'd4,   8'h10, 1'b0};
        stim[1] = '{32'h0a00_0001, 16'd6000, 16'd80,   16'd5,   8'h20, 1'b0};
        stim[2] = '{32'hc0a8_0107, 16'd5001, 16'd1234, 16'd1,   8'ha0, 1'b1};
        stim[3] = '{32'hac10_0002, 16'd7,    16'd1234, 16'd120, 8'h00, 1'b0};
        stim[4] = '{32'hc0a8_0109, 16'd53,   16'd1235, 16'd70,  8'h40, 1'b0};
        stim[5] = '{32'hc0a8_010a, 16'd4000, 16'd1234, 16'd80,  8'hf0, 1'b1};
        stim[6] = '{32'hc0a8_010b, 16'd4001, 16'd1234, 16'd3,   8'h55, 1'b0};
        stim[7] = '{32'h7f00_0001, 16'd9,    16'd1234, 16'd2,   8'hfe, 1'b0};

        total = 0;
        for (int i = 0; i < NUM; i++) begin
            total = total + int'(stim[i].len) + 1;
        end
        cycle_limit = 4 * total + RST_CYCLES;

        do @(posedge clk); while (rst);
        @(negedge clk);
        check_value("rx_hdr_ready", 32'(rx_hdr_ready), 32'd0);
        check_value("rx_payload_ready", 32'(rx_payload_ready), 32'd0);
        check_value("tx_hdr_valid", 32'(tx_hdr_valid), 32'd0);
        check_value("tx_payload_valid", 32'(tx_payload_valid), 32'd0);
        check_value("led", 32'(led), 32'd0);

        for (int i = 0; i < NUM; i++) begin
            apply_entry(i);
        end

        while (exp_dest_ip.size() != 0 || exp_byte.size() != 0) begin
            @(negedge clk);
        end
        // Idle tail catches stray replies and the final LED check
        repeat (16) @(negedge clk);
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
source/udp_echo_pkg.sv
source/udp_port_filter.sv
source/payload_fifo.sv
source/reply_builder.sv
source/udp_echo_top.sv
verif/tb_clk_gen.sv
verif/tb_udp_echo.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_udp_echo
RTL_TOP   ?= udp_echo_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= source/udp_echo_pkg.sv source/udp_port_filter.sv source/payload_fifo.sv \
             source/reply_builder.sv source/udp_echo_top.sv
TB_SRCS   ?= verif/tb_clk_gen.sv verif/tb_udp_echo.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
